// File: t05_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Boot copier constants
// Flash source, bus destination, image size and timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef T05_DEFS_SVH
`define T05_DEFS_SVH

// Image start in the SPI flash
`define T05_FLASH_BASE    24'h001000
// Wishbone address of word 0
`define T05_WB_DEST_BASE  32'h3000_0000
`define T05_COPY_WORDS    16           // 32-bit words per image
// hwclk cycles per SCK half period
`define T05_SCK_DIV       2
`define T05_FIFO_DEPTH    4            // Power of two

`endif

// File: t05_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Boot copier shared types
// Word record, bus request and reader phases
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package t05_pkg;

    // One assembled flash word and its position in the image
    typedef struct packed {
        logic [15:0] idx;   // Word index from 0
        logic [31:0] data;  // First flash byte in 7:0
    } copy_word_t;

    // Single Wishbone write request
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
        logic        we;
    } wb_req_t;

    typedef enum logic [2:0] {
        RD_IDLE,      // Waiting to open the transfer
        RD_CMD,       // Read opcode out
        RD_ADDR,      // 24-bit flash address out
        RD_DATA,      // Streaming bytes in
        RD_FINISHED   // Image read, chip deselected
    } reader_state_t;

endpackage

// File: spi_flash_reader.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI flash reader, mode 0
// Sends read 0x03 and address, streams words out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "t05_defs.svh"

module spi_flash_reader (
    input  logic                hwclk,
    input  logic                reset,
    input  logic                miso,
    input  logic                fifo_full,
    output logic                mosi,
    output logic                sck,
    output logic                cs_n,
    output logic                word_valid,
    output t05_pkg::copy_word_t word
);

    localparam logic [7:0]  DIV_LAST   = 8'(`T05_SCK_DIV - 1);
    localparam logic [15:0] WORD_TOTAL = 16'(`T05_COPY_WORDS);

    t05_pkg::reader_state_t state;

    logic [7:0]  div_cnt;   // Half period counter
    logic [31:0] tx_sr;     // Opcode then address, MSB first
    logic [6:0]  rx_sr;     // Bits of the byte in progress
    logic [4:0]  bit_cnt;   // Rising edges in phase, wraps per word in data
    logic [15:0] word_idx;  // Next word to emit
    logic        active;
    logic        hold;
    logic        tick;
    logic        rise;
    logic        fall;

    assign active = (state == t05_pkg::RD_CMD) || (state == t05_pkg::RD_ADDR) ||
                    (state == t05_pkg::RD_DATA);

    // Byte boundary with SCK low and no room downstream
    assign hold = (state == t05_pkg::RD_DATA) && !sck && (bit_cnt[2:0] == 3'd0) && fifo_full;

    assign tick = active && !hold && (div_cnt == DIV_LAST);
    assign rise = tick && !sck;   // miso sampled here
    assign fall = tick && sck;    // mosi advances here

    assign mosi = cs_n ? 1'b0 : tx_sr[31];

    // SCK divider, frozen while held
    always_ff @(posedge hwclk) begin
        if (reset) begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end else if (!active) begin
            div_cnt <= '0;
            sck     <= 1'b0;   // Idle low in mode 0
        end else if (!hold) begin
            if (tick) begin
                div_cnt <= '0;
                sck     <= ~sck;
            end else begin
                div_cnt <= div_cnt + 8'd1;
            end
        end
    end

    // Phase control
    always_ff @(posedge hwclk) begin
        if (reset) begin
            state      <= t05_pkg::RD_IDLE;
            cs_n       <= 1'b1;
            bit_cnt    <= '0;
            word_idx   <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;   // One-cycle strobe
            case (state)
                t05_pkg::RD_IDLE: begin
                    cs_n    <= 1'b0;   // Select right after reset
                    bit_cnt <= '0;
                    state   <= t05_pkg::RD_CMD;
                end
                t05_pkg::RD_CMD: begin
                    if (rise) begin
                        bit_cnt <= (bit_cnt == 5'd7) ? 5'd0 : bit_cnt + 5'd1;
                        if (bit_cnt == 5'd7)
                            state <= t05_pkg::RD_ADDR;
                    end
                end
                t05_pkg::RD_ADDR: begin
                    if (rise) begin
                        bit_cnt <= (bit_cnt == 5'd23) ? 5'd0 : bit_cnt + 5'd1;
                        if (bit_cnt == 5'd23)
                            state <= t05_pkg::RD_DATA;
                    end
                end
                t05_pkg::RD_DATA: begin
                    if (rise) begin
                        bit_cnt <= bit_cnt + 5'd1;   // Wraps every word
                        if (bit_cnt == 5'd31) begin
                            word_valid <= 1'b1;
                            word_idx   <= word_idx + 16'd1;
                        end
                    end
                    // Deselect once SCK is back low after the last word
                    if (fall && (bit_cnt == 5'd0) && (word_idx == WORD_TOTAL)) begin
                        cs_n  <= 1'b1;
                        state <= t05_pkg::RD_FINISHED;
                    end
                end
                default: cs_n <= 1'b1;   // Finished until reset
            endcase
        end
    end

    // Shift registers and word assembly
    always_ff @(posedge hwclk) begin
        if (state == t05_pkg::RD_IDLE)
            tx_sr <= {8'h03, `T05_FLASH_BASE};
        else if (fall)
            tx_sr <= {tx_sr[30:0], 1'b0};
        if (rise && (state == t05_pkg::RD_DATA)) begin
            rx_sr <= {rx_sr[5:0], miso};
            if (bit_cnt[2:0] == 3'd7)
                word.data[{bit_cnt[4:3], 3'b000} +: 8] <= {rx_sr, miso};   // Little-endian
            if (bit_cnt == 5'd31)
                word.idx <= word_idx;
        end
    end

endmodule

// File: word_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word FIFO between SPI reader and bus writer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "t05_defs.svh"

module word_fifo (
    input  logic                hwclk,
    input  logic                reset,
    input  logic                push,
    input  t05_pkg::copy_word_t word_in,
    input  logic                pop,
    output t05_pkg::copy_word_t head,
    output logic                empty,
    output logic                full
);

    localparam int DEPTH = `T05_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    t05_pkg::copy_word_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;   // Occupancy, 0 to DEPTH
    logic          do_push;
    logic          do_pop;

    assign do_push = push && !full;   // Drop on overflow
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == (AW+1)'(DEPTH));
    assign head  = mem[rd_ptr];   // Valid one cycle after push

    always_ff @(posedge hwclk) begin
        if (do_push)
            mem[wr_ptr] <= word_in;
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge hwclk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

endmodule

// File: wb_copy_writer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone copy writer
// One single write per FIFO word, done after last ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "t05_defs.svh"

module wb_copy_writer (
    input  logic                hwclk,
    input  logic                reset,
    input  t05_pkg::copy_word_t head,
    input  logic                empty,
    input  logic                ack,
    output logic                pop,
    output t05_pkg::wb_req_t    bus,
    output logic                stb,
    output logic                cyc,
    output logic                done
);

    localparam logic [15:0] LAST_WRITE = 16'(`T05_COPY_WORDS - 1);

    logic [15:0] wr_count;   // Acknowledged writes

    // Accept only between cycles; cyc low for one cycle after each ack
    assign pop = !cyc && !done && !empty;

    // Request fields, held for the whole cycle
    always_ff @(posedge hwclk) begin
        if (pop) begin
            bus.adr <= `T05_WB_DEST_BASE + {14'd0, head.idx, 2'b00};   // Byte address
            bus.dat <= head.data;
            bus.sel <= 4'hf;
            bus.we  <= 1'b1;
        end
    end

    always_ff @(posedge hwclk) begin
        if (reset) begin
            stb      <= 1'b0;
            cyc      <= 1'b0;
            done     <= 1'b0;
            wr_count <= '0;
        end else if (pop) begin
            stb <= 1'b1;
            cyc <= 1'b1;
        end else if (cyc && ack) begin
            stb      <= 1'b0;   // Drop right after ack
            cyc      <= 1'b0;
            wr_count <= wr_count + 16'd1;
            if (wr_count == LAST_WRITE)
                done <= 1'b1;   // Sticky until reset
        end
    end

endmodule

// File: t05_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Boot copier inner top
// SPI flash reader, word FIFO, Wishbone writer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module t05_top (
    input  logic        hwclk,
    input  logic        reset,
    output logic        mosi,
    input  logic        miso,
    output logic        sck,
    output logic        cs_n,
    output logic        done,
    output logic        wbs_stb_o,
    output logic        wbs_cyc_o,
    output logic        wbs_we_o,
    output logic [3:0]  wbs_sel_o,
    output logic [31:0] wbs_dat_o,
    output logic [31:0] wbs_adr_o,
    input  logic        wbs_ack_i,
    input  logic [31:0] wbs_dat_i   // Write-only master
);

    t05_pkg::copy_word_t rd_word;
    t05_pkg::copy_word_t fifo_head;
    t05_pkg::wb_req_t    wb_req;
    logic                rd_valid;
    logic                fifo_empty;
    logic                fifo_full;
    logic                wr_pop;

    spi_flash_reader reader (
        .hwclk(hwclk), .reset(reset), .miso(miso), .fifo_full(fifo_full),
        .mosi(mosi), .sck(sck), .cs_n(cs_n), .word_valid(rd_valid), .word(rd_word)
    );

    word_fifo fifo (
        .hwclk(hwclk), .reset(reset), .push(rd_valid), .word_in(rd_word),
        .pop(wr_pop), .head(fifo_head), .empty(fifo_empty), .full(fifo_full)
    );

    wb_copy_writer writer (
        .hwclk(hwclk), .reset(reset), .head(fifo_head), .empty(fifo_empty),
        .ack(wbs_ack_i), .pop(wr_pop), .bus(wb_req),
        .stb(wbs_stb_o), .cyc(wbs_cyc_o), .done(done)
    );

    // Request struct onto the bus pins
    assign wbs_adr_o = wb_req.adr;
    assign wbs_dat_o = wb_req.dat;
    assign wbs_sel_o = wb_req.sel;
    assign wbs_we_o  = wb_req.we;

endmodule

// File: team_05.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Team 05 chip wrapper
// Enable-gated reset, GPIO pin map, Wishbone master
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module team_05 (
    input  logic        clk,
    input  logic        reset,
    input  logic        en,         // Low holds the copier in reset
    output logic [31:0] adr_o,
    output logic [31:0] dat_o,
    output logic [3:0]  sel_o,
    output logic        we_o,
    output logic        stb_o,
    output logic        cyc_o,
    input  logic [31:0] dat_i,
    input  logic        ack_i,
    input  logic [33:0] gpio_in,
    output logic [33:0] gpio_out,
    output logic [33:0] gpio_oeb    // Active-low output enable
);

    // Unused pins driven low
    assign gpio_out[0]     = 1'b0;
    assign gpio_out[2]     = 1'b0;
    assign gpio_out[33:6]  = '0;

    assign gpio_oeb[0]     = 1'b1;
    assign gpio_oeb[1]     = 1'b0;   // mosi
    assign gpio_oeb[2]     = 1'b1;   // miso in
    assign gpio_oeb[5:3]   = 3'b000; // sck, cs_n, done
    assign gpio_oeb[33:6]  = '1;

    t05_top top (
        .hwclk(clk),
        .reset(reset | ~en),
        .mosi(gpio_out[1]),
        .miso(gpio_in[2]),
        .sck(gpio_out[3]),
        .cs_n(gpio_out[4]),
        .done(gpio_out[5]),
        .wbs_stb_o(stb_o),
        .wbs_cyc_o(cyc_o),
        .wbs_we_o(we_o),
        .wbs_sel_o(sel_o),
        .wbs_dat_o(dat_o),
        .wbs_adr_o(adr_o),
        .wbs_ack_i(ack_i),
        .wbs_dat_i(dat_i)
    );

endmodule

// File: tb_spi_flash_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral SPI flash, mode 0
// Checks the read header, streams image bytes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "t05_defs.svh"

module tb_spi_flash_model (
    input  logic        sck,
    input  logic        cs_n,
    input  logic        mosi,
    input  logic [7:0]  byte_data,     // Flash content at byte_addr
    output logic        miso,
    output logic [23:0] byte_addr,
    output int          headers_seen,
    output int          header_errors
);

    // Read opcode followed by the image start
    localparam logic [31:0] READ_HEADER = {8'h03, `T05_FLASH_BASE};

    int          bit_cnt = 0;   // Rising edges since select
    int          seen = 0;
    int          errs = 0;
    int          dbit;          // Data bit number after the header
    logic [31:0] hdr = '0;
    logic        miso_q = 1'b0;

    assign dbit          = bit_cnt - 32;
    assign byte_addr     = hdr[23:0] + 24'(dbit >>> 3);   // Continuous read
    assign miso          = miso_q;
    assign headers_seen  = seen;
    assign header_errors = errs;

    // Header in on rising SCK, MSB first
    always @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            bit_cnt = 0;   // Deselect ends the transfer
            hdr     = '0;
        end else begin
            if (bit_cnt < 32)
                hdr = {hdr[30:0], mosi};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 32) begin
                seen = seen + 1;
                if (hdr !== READ_HEADER) begin
                    $display("MISMATCH mosi: SPI read header was wrong, expected %h, got %h",
                             READ_HEADER, hdr);
                    errs = errs + 1;
                end
            end
        end
    end

    // Data on falling SCK, stable before the next rise
    always @(negedge sck) begin
        if (!cs_n && bit_cnt >= 32)
            miso_q <= #1 byte_data[3'd7 - 3'(dbit)];   // MSB first in each byte
    end

endmodule

// File: tb_team_05.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the team 05 boot copier
// Flash model, Wishbone memory, data and pin checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "t05_defs.svh"

module tb_team_05;

    localparam logic [31:0] SEED         = 32'hfe4c_7338;
    localparam int          WORDS        = `T05_COPY_WORDS;
    localparam int          STALL_WORD   = 10;    // Held long enough to fill the FIFO
    localparam int          STALL_CYCLES = 800;
    localparam int          QUIET_CYCLES = 100;
    localparam int          SPI_WORD     = 32 * 2 * `T05_SCK_DIV;   // Cycles per SPI word
    // Two copies with header, worst ack waits, stall, quiet check and margin
    localparam int          TIMEOUT      = 2 * (WORDS + 1) * SPI_WORD + 2 * WORDS * 8 * 7
                                           + STALL_CYCLES + QUIET_CYCLES + 500;
    localparam logic [33:0] USED_PINS    = 34'h3a;   // mosi, sck, cs_n, done

    logic        clk = 1'b0;
    logic        reset;
    logic        en;
    logic        ack_i = 1'b0;
    logic [31:0] dat_i;
    logic [33:0] gpio_in;
    logic [31:0] adr_o;
    logic [31:0] dat_o;
    logic [3:0]  sel_o;
    logic        we_o;
    logic        stb_o;
    logic        cyc_o;
    logic [33:0] gpio_out;
    logic [33:0] gpio_oeb;
    logic        mosi;
    logic        miso;
    logic        sck;
    logic        cs_n;
    logic        done;
    logic [23:0] flash_addr;
    logic [7:0]  flash_data;
    int          headers_seen;
    int          header_errors;

    t05_pkg::wb_req_t wr_q [$];            // Acknowledged writes awaiting check
    logic [31:0]      mem [logic [31:0]];  // Wishbone memory contents
    logic [31:0]      rng = SEED;          // Ack delay stream
    int               ack_wait = -1;       // -1 with no cycle open
    int               exp_idx = 0;         // Next expected word
    int               check_errors = 0;
    int               seq_errors = 0;
    int               low_run = 0;
    int               max_low_run = 0;
    int               cycles = 0;

    always #5 clk = ~clk;

    assign mosi    = gpio_out[1];
    assign sck     = gpio_out[3];
    assign cs_n    = gpio_out[4];
    assign done    = gpio_out[5];
    assign gpio_in = {31'd0, miso, 2'b00};   // miso on pin 2

    team_05 DUT (
        .clk(clk), .reset(reset), .en(en),
        .adr_o(adr_o), .dat_o(dat_o), .sel_o(sel_o), .we_o(we_o),
        .stb_o(stb_o), .cyc_o(cyc_o), .dat_i(dat_i), .ack_i(ack_i),
        .gpio_in(gpio_in), .gpio_out(gpio_out), .gpio_oeb(gpio_oeb)
    );

    tb_spi_flash_model flash (
        .sck(sck), .cs_n(cs_n), .mosi(mosi), .byte_data(flash_data), .miso(miso),
        .byte_addr(flash_addr), .headers_seen(headers_seen), .header_errors(header_errors)
    );

    assign flash_data = flash_byte(flash_addr);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] flash_byte(input logic [23:0] a);
        logic [31:0] r;
        r = xorshift32(SEED ^ {8'h00, a});
        return r[7:0];
    endfunction

    // Expected word i, first flash byte in the low bits
    function automatic logic [31:0] ref_word(input int i);
        logic [23:0] a;
        a = `T05_FLASH_BASE + 24'(4 * i);
        return {flash_byte(a + 24'd3), flash_byte(a + 24'd2), flash_byte(a + 24'd1),
                flash_byte(a)};
    endfunction

    // Ack wait for word n, long burst and one stall in the middle
    function logic [31:0] next_ack_delay(input logic [31:0] n);
        rng = xorshift32(rng);
        if (n == 32'(STALL_WORD))
            return 32'(STALL_CYCLES);
        if (n >= 32'd4 && n <= 32'd7)
            return 32'd7;
        return {29'd0, rng[2:0]};   // 0 to 7 cycles
    endfunction

    task automatic expect_pin(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("MISMATCH %s: expected %h, got %h", name, want, got);
            seq_errors++;
        end
    endtask

    // Wishbone memory, one-cycle ack after a random wait
    always @(posedge clk) begin
        if (ack_i) begin
            ack_i <= #1 1'b0;
            ack_wait = -1;
        end else if (cyc_o && stb_o && en) begin
            if (ack_wait < 0)
                ack_wait = int'(next_ack_delay((adr_o - `T05_WB_DEST_BASE) >> 2));
            if (ack_wait == 0) begin
                mem[adr_o] = dat_o;
                wr_q.push_back({adr_o, dat_o, sel_o, we_o});
                ack_i <= #1 1'b1;
            end
            ack_wait = ack_wait - 1;
        end else begin
            ack_wait = -1;   // Cycle dropped, e.g. by en low
        end
    end

    // Write checker, between clock edges
    always @(negedge clk) begin
        t05_pkg::wb_req_t w;
        logic [31:0]      exp_adr;
        if (wr_q.size() > 0) begin
            w       = wr_q.pop_front();
            exp_adr = `T05_WB_DEST_BASE + 32'(4 * exp_idx);
            if (exp_idx >= WORDS) begin
                $display("Extra write beyond the image at address %h", w.adr);
                check_errors++;
            end
            if (w.adr !== exp_adr) begin
                $display("MISMATCH adr_o: expected %h, got %h", exp_adr, w.adr);
                check_errors++;
            end
            if (w.dat !== ref_word(exp_idx)) begin
                $display("MISMATCH dat_o: expected %h, got %h", ref_word(exp_idx), w.dat);
                check_errors++;
            end
            if (w.sel !== 4'hf) begin
                $display("MISMATCH sel_o: expected %h, got %h", 4'hf, w.sel);
                check_errors++;
            end
            if (w.we !== 1'b1) begin
                $display("MISMATCH we_o: expected %h, got %h", 1'b1, w.we);
                check_errors++;
            end
            exp_idx++;
        end
        if (!en)
            exp_idx = 0;   // Copy restarts from word 0
    end

    // Longest SCK low stretch while selected
    always @(posedge clk) begin
        if (!cs_n && !sck)
            low_run = low_run + 1;
        else
            low_run = 0;
        if (low_run > max_low_run)
            max_low_run = low_run;
    end

    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: copy not finished after %0d cycles", TIMEOUT);
        $display("Errors: %0d data, %0d sequence, %0d spi header",
                 check_errors, seq_errors, header_errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        reset = 1'b1;
        en    = 1'b1;
        dat_i = '0;
        repeat (5) @(posedge clk);
        expect_pin("cs_n", cs_n, 1'b1);
        expect_pin("sck", sck, 1'b0);
        expect_pin("stb_o", stb_o, 1'b0);
        expect_pin("cyc_o", cyc_o, 1'b0);
        expect_pin("done", done, 1'b0);
        if (gpio_oeb !== 34'h3_ffff_ffc5) begin
            $display("MISMATCH gpio_oeb: expected %h, got %h", 34'h3_ffff_ffc5, gpio_oeb);
            seq_errors++;
        end
        if ((gpio_out & ~USED_PINS) !== 34'h0) begin   // Unmapped pins stay low
            $display("MISMATCH gpio_out: expected %h, got %h", 34'h0,
                     gpio_out & ~USED_PINS);
            seq_errors++;
        end
        #1 reset = 1'b0;

        // Cut the first copy short with en
        while (exp_idx < 3)
            @(posedge clk);
        #1 en = 1'b0;
        repeat (10) @(posedge clk);
        expect_pin("cs_n", cs_n, 1'b1);
        expect_pin("stb_o", stb_o, 1'b0);
        expect_pin("cyc_o", cyc_o, 1'b0);
        expect_pin("done", done, 1'b0);
        #1 en = 1'b1;

        // Full copy with slow acks and one long stall
        while (!done)
            @(posedge clk);
        repeat (2) @(posedge clk);
        if (exp_idx != WORDS) begin
            $display("Wrong number of writes after restart: %0d, expected %0d", exp_idx, WORDS);
            seq_errors++;
        end
        expect_pin("cs_n", cs_n, 1'b1);
        repeat (QUIET_CYCLES) begin
            @(posedge clk);
            expect_pin("stb_o", stb_o, 1'b0);
            expect_pin("done", done, 1'b1);
        end
        if (max_low_run < SPI_WORD) begin
            $display("SCK never paused while the FIFO was full, longest low run %0d cycles",
                     max_low_run);
            seq_errors++;
        end
        if (headers_seen != 2) begin
            $display("Flash saw %0d read headers, expected 2", headers_seen);
            seq_errors++;
        end
        for (int i = 0; i < WORDS; i++) begin
            if (!mem.exists(`T05_WB_DEST_BASE + 32'(4 * i))) begin
                $display("No write landed for word %0d", i);
                seq_errors++;
            end else if (mem[`T05_WB_DEST_BASE + 32'(4 * i)] !== ref_word(i)) begin
                $display("MISMATCH mem: expected %h, got %h", ref_word(i),
                         mem[`T05_WB_DEST_BASE + 32'(4 * i)]);
                seq_errors++;
            end
        end

        $display("Errors: %0d data, %0d sequence, %0d spi header",
                 check_errors, seq_errors, header_errors);
        if (check_errors + seq_errors + header_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the boot copier testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing -j 0 --timescale 1ns/1ps \
    --top-module tb_team_05 -f flist.f -Mdir "$BUILD" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0

// File: flist.f
+incdir+.
t05_pkg.sv
spi_flash_reader.sv
word_fifo.sv
wb_copy_writer.sv
t05_top.sv
team_05.sv
tb_spi_flash_model.sv
tb_team_05.sv
